// ==== hdl/pcie_tx_pkg.sv ====
`default_nettype none

package pcie_tx_pkg;

   // widths
   localparam int ADDR_W = 64;
   localparam int DATA_W = 64;

   // one write payload quadword, as loaded over APB
   typedef logic [DATA_W-1:0] wdata_t;

   // one stream word toward the core
   typedef struct packed {
      logic              one_dw;   // only the low DW of data is meaningful
      logic              last;     // end of TLP
      logic [DATA_W-1:0] data;
   } txw_t;

   // fixed request sizes
   localparam int RD_LEN_DW  = 128;
   localparam int WR_LEN_DW  = 32;
   localparam int WR_QWORDS  = 16;   // buffer pops per write request
   localparam int CPL_LEN_DW = 2;

   // completion with data, 3-DW header, length in the low bits
   localparam logic [31:0] CPL_HDR0  = {8'h4A, 14'd0, 10'(CPL_LEN_DW)};
   localparam logic [15:0] CPL_BYTES = 16'd8;
   localparam logic [7:0]  BE_ALL    = 8'hFF;   // first/last byte enables

   // buffering
   localparam int TLP_MAX_WORDS = 18;   // write request, header plus payload
   localparam int TXF_DEPTH     = 32;
   localparam int WBUF_DEPTH    = 16;

   // APB register map
   localparam logic [7:0] REG_ADDR_LO  = 8'h00;
   localparam logic [7:0] REG_ADDR_HI  = 8'h04;
   localparam logic [7:0] REG_TAG      = 8'h08;
   localparam logic [7:0] REG_WDATA_LO = 8'h0C;
   localparam logic [7:0] REG_WDATA_HI = 8'h10;
   localparam logic [7:0] REG_CMD      = 8'h14;
   localparam logic [7:0] REG_STATUS   = 8'h18;

   // CMD register bit positions
   localparam int CMD_RD = 0;
   localparam int CMD_WR = 1;

endpackage

`default_nettype wire

// ==== hdl/fwft_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module fwft_fifo #(
   parameter type payload_t = logic [63:0],
   parameter int  DEPTH     = 16,
   parameter int  ROOM      = 1
) (
   input  wire           clock,
   input  wire           reset,
   input  wire           i_push,
   input  wire payload_t i_data,
   input  wire           i_pop,
   output payload_t      o_data,
   output logic          o_valid,
   output logic          o_room,
   output logic          o_full,
   output logic [5:0]    o_count
);

   payload_t                   mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic                       do_push;
   logic                       do_pop;

   assign do_push = i_push && !o_full;
   assign do_pop  = i_pop && o_valid;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         o_count <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         o_count <= o_count + 6'(do_push) - 6'(do_pop);
      end
   end

   always_ff @(posedge clock)
   begin
      if (do_push)
         mem[wr_ptr] <= i_data;
   end

   assign o_data  = mem[rd_ptr];   // head word, no read needed
   assign o_valid = o_count != 6'd0;
   assign o_full  = o_count == 6'(DEPTH);
   assign o_room  = (DEPTH - int'(o_count)) >= ROOM;

   a_no_overflow: assert property (@(posedge clock) disable iff (reset) !(i_push && o_full));
   a_no_underflow: assert property (@(posedge clock) disable iff (reset) !(i_pop && !o_valid));

endmodule

`default_nettype wire

// ==== hdl/pcie_req_apb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_req_apb (
   input  wire                             clock,
   input  wire                             reset,
   input  wire                             i_psel,
   input  wire                             i_penable,
   input  wire                             i_pwrite,
   input  wire [7:0]                       i_paddr,
   input  wire [31:0]                      i_pwdata,
   output logic [31:0]                     o_prdata,
   output logic                            o_pready,
   output logic                            o_pslverr,
   input  wire [5:0]                       i_wbuf_count,
   input  wire                             i_wbuf_full,
   output logic                            o_wbuf_push,
   output pcie_tx_pkg::wdata_t             o_wbuf_data,
   output logic                            o_rr_valid,
   output logic [pcie_tx_pkg::ADDR_W-1:0]  o_rr_addr,
   output logic [7:0]                      o_rr_tag,
   input  wire                             i_rr_ready,
   output logic                            o_wr_valid,
   output logic [pcie_tx_pkg::ADDR_W-1:0]  o_wr_addr,
   input  wire                             i_wr_ready
);

   logic [31:0] addr_lo;
   logic [31:0] addr_hi;
   logic [7:0]  tag;
   logic [31:0] data_lo;
   logic [3:0]  wr_beats;   // wr_ready pulses seen for the current write
   logic        wr_acc;
   logic        cmd_acc;
   logic        want_rd;
   logic        want_wr;
   logic        push_err;
   logic        cmd_err;

   assign wr_acc   = i_psel && i_penable && i_pwrite;
   assign cmd_acc  = wr_acc && (i_paddr == pcie_tx_pkg::REG_CMD);
   assign want_rd  = cmd_acc && i_pwdata[pcie_tx_pkg::CMD_RD];
   assign want_wr  = cmd_acc && i_pwdata[pcie_tx_pkg::CMD_WR];
   assign push_err = wr_acc && (i_paddr == pcie_tx_pkg::REG_WDATA_HI) && i_wbuf_full;
   // a second command of one kind, or a write without a full payload
   assign cmd_err  = (want_rd && o_rr_valid) ||
                     (want_wr && (o_wr_valid || i_wbuf_count < 6'(pcie_tx_pkg::WR_QWORDS)));

   assign o_pready    = i_psel && i_penable;   // zero wait states
   assign o_pslverr   = push_err || cmd_err;
   assign o_wbuf_push = wr_acc && (i_paddr == pcie_tx_pkg::REG_WDATA_HI) && !i_wbuf_full;
   assign o_wbuf_data = {i_pwdata, data_lo};

   always_comb
   begin
      case (i_paddr)
         pcie_tx_pkg::REG_ADDR_LO:  o_prdata = addr_lo;
         pcie_tx_pkg::REG_ADDR_HI:  o_prdata = addr_hi;
         pcie_tx_pkg::REG_TAG:      o_prdata = {24'd0, tag};
         pcie_tx_pkg::REG_WDATA_LO: o_prdata = data_lo;
         pcie_tx_pkg::REG_STATUS:   o_prdata = {19'd0, i_wbuf_count[4:0], 6'd0, o_wr_valid, o_rr_valid};
         default:                   o_prdata = 32'd0;
      endcase
   end

   // field registers and posted request fields
   always_ff @(posedge clock)
   begin
      if (wr_acc && i_paddr == pcie_tx_pkg::REG_ADDR_LO)
         addr_lo <= i_pwdata;
      if (wr_acc && i_paddr == pcie_tx_pkg::REG_ADDR_HI)
         addr_hi <= i_pwdata;
      if (wr_acc && i_paddr == pcie_tx_pkg::REG_TAG)
         tag <= i_pwdata[7:0];
      if (wr_acc && i_paddr == pcie_tx_pkg::REG_WDATA_LO)
         data_lo <= i_pwdata;
      if (want_rd && !cmd_err)
      begin
         o_rr_addr <= {addr_hi, addr_lo};
         o_rr_tag  <= tag;
      end
      if (want_wr && !cmd_err)
         o_wr_addr <= {addr_hi, addr_lo};
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         o_rr_valid <= 1'b0;
         o_wr_valid <= 1'b0;
         wr_beats   <= 4'd0;
      end
      else
      begin
         if (want_rd && !cmd_err)
            o_rr_valid <= 1'b1;
         else if (i_rr_ready)
            o_rr_valid <= 1'b0;
         if (want_wr && !cmd_err)
            o_wr_valid <= 1'b1;
         else if (o_wr_valid && i_wr_ready)
         begin
            if (wr_beats == 4'(pcie_tx_pkg::WR_QWORDS - 1))
            begin
               o_wr_valid <= 1'b0;   // last quadword taken
               wr_beats   <= 4'd0;
            end
            else
               wr_beats <= wr_beats + 4'd1;
         end
      end
   end

   a_rr_hold: assert property (@(posedge clock) disable iff (reset)
      o_rr_valid && !i_rr_ready |=> o_rr_valid && $stable(o_rr_addr) && $stable(o_rr_tag));

endmodule

`default_nettype wire

// ==== hdl/pcie_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_tx (
   input  wire                             clock,
   input  wire                             reset,
   input  wire [15:0]                      i_pcie_id,
   input  wire                             i_rc_done,
   input  wire [31:0]                      i_rc_dw2,
   input  wire [63:0]                      i_rc_data,
   input  wire                             i_rr_valid,
   input  wire [pcie_tx_pkg::ADDR_W-1:0]   i_rr_addr,
   input  wire [7:0]                       i_rr_tag,
   output logic                            o_rr_ready,
   input  wire                             i_wr_valid,
   input  wire [pcie_tx_pkg::ADDR_W-1:0]   i_wr_addr,
   output logic                            o_wr_ready,
   input  wire pcie_tx_pkg::wdata_t        i_wr_data,
   output logic                            o_push,
   output pcie_tx_pkg::txw_t               o_word,
   input  wire                             i_room
);

   logic [4:0]          state;   // 1-3 cpl, 4-5 read, 6-23 write
   logic                rc_pend;
   logic                rc_go;
   logic                rr_go;
   logic                wr_go;
   logic                boundary;
   logic                rr_is_32;
   logic                wr_is_32;
   logic                wr_is_32_q;
   pcie_tx_pkg::wdata_t wr_data_q;   // previous quadword for 3-DW straddling

   function automatic logic [31:0] es(input logic [31:0] x);
      es = {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   assign rr_is_32 = i_rr_addr[63:32] == 32'd0;
   assign wr_is_32 = i_wr_addr[63:32] == 32'd0;

   assign boundary   = (state == 5'd0) || (state == 5'd3) || (state == 5'd5) || (state == 5'd23);
   assign o_rr_ready = state == 5'd5;
   // 3-DW form takes its first payload DW in the address word
   assign o_wr_ready = wr_is_32_q ? (state >= 5'd7 && state <= 5'd22)
                                  : (state >= 5'd8 && state <= 5'd23);

   // requests being finished this cycle are not eligible again
   assign rc_go = rc_pend && (state != 5'd3);
   assign rr_go = i_rr_valid && !o_rr_ready;
   assign wr_go = i_wr_valid && !o_wr_ready;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         rc_pend <= 1'b0;
         state   <= 5'd0;
         o_push  <= 1'b0;
      end
      else
      begin
         if (i_rc_done)
            rc_pend <= 1'b1;
         else if (state == 5'd3)
            rc_pend <= 1'b0;
         if (boundary)
            state <= !i_room ? 5'd0 : rc_go ? 5'd1 : rr_go ? 5'd4 : wr_go ? 5'd6 : 5'd0;
         else
            state <= state + 5'd1;
         o_push <= state != 5'd0;
      end
   end

   always_ff @(posedge clock)
   begin
      if (state == 5'd6)
         wr_is_32_q <= wr_is_32;
      if (o_wr_ready)
         wr_data_q <= i_wr_data;
      case (state)
         5'd0: o_word <= '0;
         // completion
         5'd1: o_word <= {2'b00, i_pcie_id, pcie_tx_pkg::CPL_BYTES, pcie_tx_pkg::CPL_HDR0};
         5'd2: o_word <= {2'b00, es(i_rc_data[31:0]), i_rc_dw2};
         5'd3: o_word <= {2'b11, 32'd0, es(i_rc_data[63:32])};
         // read request
         5'd4: o_word <= {2'b00, i_pcie_id, i_rr_tag, pcie_tx_pkg::BE_ALL,
                          2'b00, !rr_is_32, 29'(pcie_tx_pkg::RD_LEN_DW)};
         5'd5: o_word <= rr_is_32 ? {2'b11, i_rr_addr[31:0], i_rr_addr[31:0]}
                                  : {2'b01, i_rr_addr[31:0], i_rr_addr[63:32]};
         // write request
         5'd6: o_word <= {2'b00, i_pcie_id, 8'h00, pcie_tx_pkg::BE_ALL,
                          2'b01, !wr_is_32, 29'(pcie_tx_pkg::WR_LEN_DW)};
         5'd7: o_word <= wr_is_32_q ? {2'b00, es(i_wr_data[31:0]), i_wr_addr[31:0]}
                                    : {2'b00, i_wr_addr[31:0], i_wr_addr[63:32]};
         5'd23: o_word <= wr_is_32_q ? {2'b11, 32'd0, es(wr_data_q[63:32])}
                                     : {2'b01, es(i_wr_data[63:32]), es(i_wr_data[31:0])};
         default: o_word <= wr_is_32_q ? {2'b00, es(i_wr_data[31:0]), es(wr_data_q[63:32])}
                                       : {2'b00, es(i_wr_data[63:32]), es(i_wr_data[31:0])};
      endcase
   end

   // a start refused for lack of room lets the pipeline drain and stops
   a_hold_no_push: assert property (@(posedge clock) disable iff (reset)
      boundary && (rc_go || rr_go || wr_go) && !i_room |=> ##1 !o_push);

endmodule

`default_nettype wire

// ==== hdl/pcie_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_tx_top (
   input  wire         clock,
   input  wire         reset,
   input  wire         i_psel,
   input  wire         i_penable,
   input  wire         i_pwrite,
   input  wire [7:0]   i_paddr,
   input  wire [31:0]  i_pwdata,
   output logic [31:0] o_prdata,
   output logic        o_pready,
   output logic        o_pslverr,
   input  wire [15:0]  i_pcie_id,
   input  wire         i_rc_done,
   input  wire [31:0]  i_rc_dw2,
   input  wire [63:0]  i_rc_data,
   output logic [63:0] o_tx_tdata,
   output logic        o_tx_tlast,
   output logic        o_tx_1dw,
   output logic        o_tx_tvalid,
   input  wire         i_tx_tready
);

   logic [5:0]                      wbuf_count;
   logic                            wbuf_full;
   logic                            wbuf_push;
   pcie_tx_pkg::wdata_t             wbuf_data;
   pcie_tx_pkg::wdata_t             wbuf_head;
   logic                            rr_valid;
   logic [pcie_tx_pkg::ADDR_W-1:0]  rr_addr;
   logic [7:0]                      rr_tag;
   logic                            rr_ready;
   logic                            wr_valid;
   logic [pcie_tx_pkg::ADDR_W-1:0]  wr_addr;
   logic                            wr_ready;   // also the write buffer pop
   logic                            txf_push;
   logic                            txf_room;
   pcie_tx_pkg::txw_t               txf_in;
   pcie_tx_pkg::txw_t               txf_out;

   pcie_req_apb u_apb (
      .clock(clock), .reset(reset),
      .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
      .i_paddr(i_paddr), .i_pwdata(i_pwdata),
      .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
      .i_wbuf_count(wbuf_count), .i_wbuf_full(wbuf_full),
      .o_wbuf_push(wbuf_push), .o_wbuf_data(wbuf_data),
      .o_rr_valid(rr_valid), .o_rr_addr(rr_addr), .o_rr_tag(rr_tag), .i_rr_ready(rr_ready),
      .o_wr_valid(wr_valid), .o_wr_addr(wr_addr), .i_wr_ready(wr_ready)
   );

   fwft_fifo #(.payload_t(pcie_tx_pkg::wdata_t), .DEPTH(pcie_tx_pkg::WBUF_DEPTH), .ROOM(1)) u_wbuf (
      .clock(clock), .reset(reset),
      .i_push(wbuf_push), .i_data(wbuf_data), .i_pop(wr_ready),
      .o_data(wbuf_head), .o_valid(), .o_room(), .o_full(wbuf_full), .o_count(wbuf_count)
   );

   pcie_tx u_tx (
      .clock(clock), .reset(reset), .i_pcie_id(i_pcie_id),
      .i_rc_done(i_rc_done), .i_rc_dw2(i_rc_dw2), .i_rc_data(i_rc_data),
      .i_rr_valid(rr_valid), .i_rr_addr(rr_addr), .i_rr_tag(rr_tag), .o_rr_ready(rr_ready),
      .i_wr_valid(wr_valid), .i_wr_addr(wr_addr), .o_wr_ready(wr_ready),
      .i_wr_data(wbuf_head), .o_push(txf_push), .o_word(txf_in), .i_room(txf_room)
   );

   // two extra entries cover the words still in the builder pipeline
   fwft_fifo #(.payload_t(pcie_tx_pkg::txw_t), .DEPTH(pcie_tx_pkg::TXF_DEPTH),
               .ROOM(pcie_tx_pkg::TLP_MAX_WORDS + 2)) u_txf (
      .clock(clock), .reset(reset),
      .i_push(txf_push), .i_data(txf_in), .i_pop(o_tx_tvalid && i_tx_tready),
      .o_data(txf_out), .o_valid(o_tx_tvalid), .o_room(txf_room), .o_full(), .o_count()
   );

   assign o_tx_1dw   = txf_out.one_dw;
   assign o_tx_tlast = txf_out.last;
   assign o_tx_tdata = txf_out.data;

endmodule

`default_nettype wire

// ==== verif/pcie_tx_model.svh ====
// expected stream words, oldest first
pcie_tx_pkg::txw_t exp_q[$];

// PCIe payload order, byte 0 of a DW goes first
function automatic logic [31:0] byte_swap(input logic [31:0] x);
   byte_swap = {x[7:0], x[15:8], x[23:16], x[31:24]};
endfunction

function automatic void add_word(input logic one_dw, input logic last, input logic [63:0] data);
   pcie_tx_pkg::txw_t w;
   w.one_dw = one_dw;
   w.last   = last;
   w.data   = data;
   exp_q.push_back(w);
endfunction

// MRd, 128 DW, fmt bit 29 selects the 4-DW header
function automatic void expect_read(input logic [63:0] addr, input logic [7:0] tag);
   logic is64;
   is64 = addr[63:32] != 32'd0;
   add_word(1'b0, 1'b0, {pcie_id, tag, 8'hFF, 2'b00, is64, 29'd128});
   if (is64)
      add_word(1'b0, 1'b1, {addr[31:0], addr[63:32]});
   else
      add_word(1'b1, 1'b1, {addr[31:0], addr[31:0]});
endfunction

// MWr, 32 DW, payload straddles words in the 3-DW form
function automatic void expect_write(input logic [63:0] addr, input pcie_tx_pkg::wdata_t qw [16]);
   logic is64;
   is64 = addr[63:32] != 32'd0;
   add_word(1'b0, 1'b0, {pcie_id, 8'h00, 8'hFF, 2'b01, is64, 29'd32});
   if (is64)
   begin
      add_word(1'b0, 1'b0, {addr[31:0], addr[63:32]});
      for (int i = 0; i < 15; i++)
         add_word(1'b0, 1'b0, {byte_swap(qw[i][63:32]), byte_swap(qw[i][31:0])});
      add_word(1'b0, 1'b1, {byte_swap(qw[15][63:32]), byte_swap(qw[15][31:0])});
   end
   else
   begin
      add_word(1'b0, 1'b0, {byte_swap(qw[0][31:0]), addr[31:0]});
      for (int i = 1; i < 16; i++)
         add_word(1'b0, 1'b0, {byte_swap(qw[i][31:0]), byte_swap(qw[i-1][63:32])});
      add_word(1'b1, 1'b1, {32'd0, byte_swap(qw[15][63:32])});
   end
endfunction

// CplD, 2 DW, 8 bytes
function automatic void expect_completion(input logic [31:0] dw2, input logic [63:0] data);
   add_word(1'b0, 1'b0, {pcie_id, 16'h0008, 32'h4A00_0002});
   add_word(1'b0, 1'b0, {byte_swap(data[31:0]), dw2});
   add_word(1'b1, 1'b1, {32'd0, byte_swap(data[63:32])});
endfunction

// ==== verif/pcie_tx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_tx_tb;

   localparam int EXP_WORDS = 4 + 36 + 8 + 8 * 18 + 20;   // all phases, random ones as writes
   localparam int TIMEOUT   = 40 * EXP_WORDS + 2000;

   logic        clock = 1'b0;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [15:0] pcie_id;
   logic        rc_done;
   logic [31:0] rc_dw2;
   logic [63:0] rc_data;
   logic [63:0] tx_tdata;
   logic        tx_tlast;
   logic        tx_1dw;
   logic        tx_tvalid;
   logic        tx_tready;

   integer              seed = 32'h81f5_d80c;
   int                  cycle_count = 0;
   logic                ready_random = 1'b0;
   int                  stretch = 0;
   pcie_tx_pkg::txw_t   got_word;
   pcie_tx_pkg::wdata_t qw [16];
   logic [63:0]         addr;
   logic [7:0]          cur_tag;
   logic [31:0]         rd;
   logic                err;

   `include "pcie_tx_model.svh"

   pcie_tx_top u_dut (
      .clock(clock), .reset(reset),
      .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
      .i_paddr(paddr), .i_pwdata(pwdata),
      .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
      .i_pcie_id(pcie_id), .i_rc_done(rc_done), .i_rc_dw2(rc_dw2), .i_rc_data(rc_data),
      .o_tx_tdata(tx_tdata), .o_tx_tlast(tx_tlast), .o_tx_1dw(tx_1dw),
      .o_tx_tvalid(tx_tvalid), .i_tx_tready(tx_tready)
   );

   always #10 clock = !clock;

   task automatic fail_run();
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_word(input pcie_tx_pkg::txw_t got, input pcie_tx_pkg::txw_t exp);
      if (got !== exp)
      begin
         $display("FAILED o_tx_tdata/o_tx_tlast/o_tx_1dw got %h/%h/%h expected %h/%h/%h",
                  got.data, got.last, got.one_dw, exp.data, exp.last, exp.one_dw);
         fail_run();
      end
   endtask

   task automatic check_apb(input logic [31:0] got_data, input logic got_err,
                            input logic [31:0] exp_data, input logic exp_err);
      if (got_err !== exp_err)
      begin
         $display("FAILED o_pslverr got %h expected %h", got_err, exp_err);
         fail_run();
      end
      if (got_data !== exp_data)
      begin
         $display("FAILED o_prdata got %h expected %h", got_data, exp_data);
         fail_run();
      end
   endtask

   // setup, access, then sample before the access edge
   task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] d,
                             output logic [31:0] data, output logic slverr);
      @(posedge clock);
      #1 psel = 1'b1;
      pwrite = wr;
      paddr  = a;
      pwdata = d;
      @(posedge clock);
      #1 penable = 1'b1;
      @(negedge clock);
      if (pready !== 1'b1)
      begin
         $display("APB access to offset %h did not complete in its access phase", a);
         fail_run();
      end
      data   = prdata;
      slverr = pslverr;
      @(posedge clock);
      #1 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] a, input logic [31:0] d, input logic exp_err);
      logic [31:0] data;
      logic        slverr;
      apb_access(1'b1, a, d, data, slverr);
      check_apb(32'd0, slverr, 32'd0, exp_err);   // write data is not read back
   endtask

   task automatic apb_read(input logic [7:0] a, output logic [31:0] data, output logic slverr);
      apb_access(1'b0, a, 32'd0, data, slverr);
   endtask

   task automatic set_address(input logic [63:0] a);
      apb_write(pcie_tx_pkg::REG_ADDR_LO, a[31:0], 1'b0);
      apb_write(pcie_tx_pkg::REG_ADDR_HI, a[63:32], 1'b0);
   endtask

   task automatic fill_random_qwords();
      for (int i = 0; i < 16; i++)
         qw[i] = {$random(seed), $random(seed)};
   endtask

   task automatic load_buffer();
      for (int i = 0; i < 16; i++)
      begin
         apb_write(pcie_tx_pkg::REG_WDATA_LO, qw[i][31:0], 1'b0);
         apb_write(pcie_tx_pkg::REG_WDATA_HI, qw[i][63:32], 1'b0);
      end
   endtask

   task automatic post_read(input logic [63:0] a, input logic [7:0] tag);
      set_address(a);
      apb_write(pcie_tx_pkg::REG_TAG, {24'd0, tag}, 1'b0);
      expect_read(a, tag);
      apb_write(pcie_tx_pkg::REG_CMD, 32'h1, 1'b0);
   endtask

   task automatic post_write(input logic [63:0] a);
      set_address(a);
      load_buffer();
      expect_write(a, qw);
      apb_write(pcie_tx_pkg::REG_CMD, 32'h2, 1'b0);
   endtask

   task automatic pulse_completion();
      @(posedge clock);
      #1 rc_done = 1'b1;
      @(posedge clock);
      #1 rc_done = 1'b0;
   endtask

   task automatic random_address(output logic [63:0] a);
      a[31:0]  = $random(seed) & 32'hFFFF_FFFC;
      a[63:32] = ($random(seed) & 1) ? 32'd0 : $random(seed);
   endtask

   // both pending flags low
   task automatic wait_idle();
      logic [31:0] data;
      logic        slverr;
      do
         apb_read(pcie_tx_pkg::REG_STATUS, data, slverr);
      while (data[1:0] != 2'b00);
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(posedge clock);
      repeat (6) @(posedge clock);   // catch stray words
   endtask

   always @(posedge clock)
   begin
      #1;
      if (!ready_random)
         tx_tready = 1'b1;
      else if (stretch == 0)
      begin
         tx_tready = $random(seed) & 1;
         stretch   = 1 + ($random(seed) & 127);   // long stretches either way
      end
      else
         stretch = stretch - 1;
   end

   always @(negedge clock)
   begin
      if (!reset && tx_tvalid && tx_tready)
      begin
         got_word.one_dw = tx_1dw;
         got_word.last   = tx_tlast;
         got_word.data   = tx_tdata;
         if (exp_q.size() == 0)
         begin
            $display("stream word %h arrived with none expected", tx_tdata);
            fail_run();
         end
         else
            check_word(got_word, exp_q.pop_front());
      end
   end

   always @(posedge clock)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT)
      begin
         $display("timeout after %0d cycles with %0d words outstanding", TIMEOUT, exp_q.size());
         fail_run();
      end
   end

   initial
   begin
      reset = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = 8'd0;
      pwdata = 32'd0;
      pcie_id = 16'h01A0;
      rc_done = 1'b0;
      rc_dw2 = 32'd0;
      rc_data = 64'd0;
      tx_tready = 1'b1;
      repeat (8) @(posedge clock);
      #1 reset = 1'b0;
      @(negedge clock);
      if (tx_tvalid !== 1'b0 || pready !== 1'b0 || pslverr !== 1'b0)
      begin
         $display("outputs not idle after reset");
         fail_run();
      end
      apb_read(pcie_tx_pkg::REG_STATUS, rd, err);
      check_apb(rd, err, 32'd0, 1'b0);

      // reads in both address forms
      post_read(64'h0000_0000_1234_5678, 8'h11);
      wait_drain();
      post_read(64'h0000_00AB_CDEF_0120, 8'h22);
      cur_tag = 8'h22;
      wait_drain();

      // writes in both address forms
      fill_random_qwords();
      post_write(64'h0000_0000_8000_1000);
      wait_drain();
      fill_random_qwords();
      post_write(64'h0000_0001_0000_2000);
      wait_drain();

      // completion alone, then with a read posted at the same time
      rc_dw2  = $random(seed);
      rc_data = {$random(seed), $random(seed)};
      expect_completion(rc_dw2, rc_data);
      pulse_completion();
      wait_drain();
      rc_dw2  = $random(seed);
      rc_data = {$random(seed), $random(seed)};
      addr    = 64'h0000_0000_0000_4440;
      set_address(addr);
      expect_completion(rc_dw2, rc_data);
      expect_read(addr, cur_tag);
      fork
         begin
            @(posedge clock);   // completion latched on the edge that posts the read
            pulse_completion();
         end
         apb_write(pcie_tx_pkg::REG_CMD, 32'h1, 1'b0);
      join
      wait_drain();

      // random requests under back-pressure
      ready_random = 1'b1;
      for (int n = 0; n < 8; n++)
      begin
         wait_idle();
         random_address(addr);
         if ($random(seed) & 1)
         begin
            cur_tag = $random(seed);
            post_read(addr, cur_tag);
         end
         else
         begin
            fill_random_qwords();
            post_write(addr);
         end
      end
      wait_drain();
      ready_random = 1'b0;

      // APB error cases
      apb_write(pcie_tx_pkg::REG_CMD, 32'h2, 1'b1);   // buffer empty
      fill_random_qwords();
      load_buffer();
      apb_write(pcie_tx_pkg::REG_WDATA_LO, 32'hDEAD_0001, 1'b0);
      apb_write(pcie_tx_pkg::REG_WDATA_HI, 32'hDEAD_0002, 1'b1);   // buffer full
      apb_read(pcie_tx_pkg::REG_STATUS, rd, err);
      check_apb(rd, err, 32'h0000_1000, 1'b0);
      addr = 64'h0000_0000_9000_0000;
      set_address(addr);
      expect_write(addr, qw);
      apb_write(pcie_tx_pkg::REG_CMD, 32'h2, 1'b0);
      apb_write(pcie_tx_pkg::REG_CMD, 32'h2, 1'b1);   // write still pending
      expect_read(addr, cur_tag);
      apb_write(pcie_tx_pkg::REG_CMD, 32'h1, 1'b0);
      apb_write(pcie_tx_pkg::REG_CMD, 32'h1, 1'b1);   // read waits behind the write
      wait_drain();
      apb_read(pcie_tx_pkg::REG_STATUS, rd, err);
      check_apb(rd, err, 32'd0, 1'b0);

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
hdl/pcie_tx_pkg.sv
hdl/fwft_fifo.sv
hdl/pcie_req_apb.sv
hdl/pcie_tx.sv
hdl/pcie_tx_top.sv
verif/pcie_tx_tb.sv

// ==== Makefile ====
# Verilator flow for the PCIe TX subsystem

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP_TB    ?= pcie_tx_tb
TOP_RTL   ?= pcie_tx_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= >>> PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP_TB)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP_RTL)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) \
		--Mdir $(BUILD_DIR) -o V$(TOP_TB)

sim: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
